// ==== rtl/pager_defs.svh ====
////////////////////////////////////////////////////////////////////////////
// port numbers and widths of the memory paging unit
// window port and mode port decode only the low address byte
////////////////////////////////////////////////////////////////////////////
`ifndef PAGER_DEFS_SVH
`define PAGER_DEFS_SVH

// four 16 KB windows in the Z80 space
`define PAGER_NUM_WIN    4
`define PAGER_WIN_AW     14

// page number, gives 1 MB of physical space
`define PAGER_PAGE_W     6

// pentagon paging port, full decode
`define PAGER_PORT_7FFD  16'h7FFD

// window page port, a[15:14] selects the window
`define PAGER_LO_WIN     8'hF7
// mode port, d[0] turns the pagers on
`define PAGER_LO_MODE    8'hBF
// page readback port, a[10:8] selects the register
`define PAGER_LO_RB      8'hBE

`endif

// ==== rtl/pager_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// types shared by the paging unit
// page register reset value is RAM page 0
////////////////////////////////////////////////////////////////////////////
`include "pager_defs.svh"

package pager_pkg;

	// decoded I/O operation
	typedef enum logic [2:0]
	{
		PORT_NONE,
		PORT_W7FFD,
		PORT_WWIN,
		PORT_WMODE,
		PORT_RB
	} port_op_e;

	typedef logic [`PAGER_PAGE_W-1:0] page_t;

	// one page register as seen on the readback port
	typedef struct packed
	{
		logic  is_rom;
		logic  rsvd;
		page_t page;
	} page_reg_t;

	typedef logic [1:0] win_idx_t;

	// page on top, offset inside the window below
	typedef struct packed
	{
		page_t                   page;
		logic [`PAGER_WIN_AW-1:0] offs;
	} phys_addr_t;

endpackage

// ==== rtl/pager_ifs.sv ====
////////////////////////////////////////////////////////////////////////////
// pager configuration bus and per-window mapping bus
// win_wr is a one-cycle strobe, at most one bit high
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "pager_defs.svh"

// port decoder to all window pagers
interface pager_cfg_if;
	import pager_pkg::*;

	logic [`PAGER_NUM_WIN-1:0] win_wr;
	page_reg_t                 wdata;
	logic                      set_sel;
	logic                      pager_on;
	page_t                     ram3_page;

	modport src
	(
		output win_wr,
		output wdata,
		output set_sel,
		output pager_on,
		output ram3_page
	);

	modport dst
	(
		input win_wr,
		input wdata,
		input set_sel,
		input pager_on,
		input ram3_page
	);

endinterface

// one window pager to the resolver
interface win_map_if;
	import pager_pkg::*;

	page_reg_t map;
	page_reg_t reg0;
	page_reg_t reg1;
	logic      wr_protect;

	modport src
	(
		output map,
		output reg0,
		output reg1,
		output wr_protect
	);

	modport dst
	(
		input map,
		input reg0,
		input reg1,
		input wr_protect
	);

endinterface

// ==== rtl/port_decoder.sv ====
////////////////////////////////////////////////////////////////////////////
// I/O write decode with the 7FFD and mode registers
// 7FFD lock is cleared by reset only
// window strobes lag io_wr by 1 cycle
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "pager_defs.svh"

module port_decoder
(
	input  logic        fclk,
	input  logic        arst_n,

	input  logic        io_wr,
	input  logic [15:0] io_addr,
	input  logic [ 7:0] io_wdata,

	pager_cfg_if.src    cfg
);
	import pager_pkg::*;

	port_op_e                  op;
	logic [7:0]                p7ffd;
	logic                      pager_on;
	logic [`PAGER_NUM_WIN-1:0] win_wr;
	page_reg_t                 wdata;

	////////////////////////////////////////////////////////////////////////////
	// write classification
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		op = PORT_NONE;
		if (io_wr)
		begin
			if (io_addr == `PAGER_PORT_7FFD)
				op = PORT_W7FFD;
			else if (io_addr[7:0] == `PAGER_LO_WIN)
				op = PORT_WWIN;
			else if (io_addr[7:0] == `PAGER_LO_MODE)
				op = PORT_WMODE;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			p7ffd    <= '0;
			pager_on <= 1'b0;
			win_wr   <= '0;
		end
		else
		begin
			win_wr <= '0;
			case (op)
				PORT_W7FFD:
				begin
					// bit 5 locks the port until reset
					if (!p7ffd[5])
						p7ffd <= io_wdata;
				end
				PORT_WMODE:
					pager_on <= io_wdata[0];
				PORT_WWIN:
					win_wr[io_addr[15:14]] <= 1'b1;
				default:
				begin
				end
			endcase
		end
	end

	// data goes out together with the strobe
	always_ff @(posedge fclk)
	begin
		if (op == PORT_WWIN)
			wdata <= page_reg_t'(io_wdata);
	end

	assign cfg.win_wr    = win_wr;
	assign cfg.wdata     = wdata;
	assign cfg.set_sel   = p7ffd[4];
	assign cfg.pager_on  = pager_on;
	assign cfg.ram3_page = page_t'(p7ffd[2:0]);

	// strobes stay one-hot
	a_win_wr_onehot: assert property (@(posedge fclk) disable iff (!arst_n)
		$onehot0(win_wr));

endmodule

// ==== rtl/window_pager.sv ====
////////////////////////////////////////////////////////////////////////////
// page registers of one 16 KB window
// WIN must be 0..3, it picks the strobe bit and the pentagon mapping
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "pager_defs.svh"

module window_pager #(
	parameter int WIN = 0
)
(
	input  logic     fclk,
	input  logic     arst_n,

	pager_cfg_if.dst cfg,
	win_map_if.src   win
);
	import pager_pkg::*;

	page_reg_t reg0;
	page_reg_t reg1;
	page_reg_t pent_map;
	page_reg_t eff_map;

	// set_sel picks which of the two registers takes the write
	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			reg0 <= '0;
			reg1 <= '0;
		end
		else if (cfg.win_wr[WIN])
		begin
			if (cfg.set_sel)
				reg1 <= cfg.wdata;
			else
				reg0 <= cfg.wdata;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// fixed pentagon-128 mapping
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		pent_map = '0;
		case (WIN)
			0:
			begin
				// 128 or 48 basic ROM
				pent_map.is_rom = 1'b1;
				pent_map.page   = page_t'(cfg.set_sel);
			end
			1:
				pent_map.page = page_t'(5);
			2:
				pent_map.page = page_t'(2);
			default:
				pent_map.page = cfg.ram3_page;
		endcase
	end

	always_comb
	begin
		if (cfg.pager_on)
			eff_map = cfg.set_sel ? reg1 : reg0;
		else
			eff_map = pent_map;
	end

	assign win.map        = eff_map;
	assign win.reg0       = reg0;
	assign win.reg1       = reg1;
	assign win.wr_protect = eff_map.is_rom;

	// mode must be settled whenever the decoder strobes this window
	a_mode_known: assert property (@(posedge fclk) disable iff (!arst_n)
		cfg.win_wr[WIN] |-> !$isunknown({cfg.pager_on, cfg.set_sel}));

endmodule

// ==== rtl/page_resolver.sv ====
////////////////////////////////////////////////////////////////////////////
// address translation, 2-cycle pipeline, no back-pressure
// readback answers 1 cycle after io_rd, other ports read as FF
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "pager_defs.svh"

module page_resolver
(
	input  logic                  fclk,
	input  logic                  arst_n,

	// memory lookup
	input  logic                  mem_valid,
	input  logic [15:0]           mem_addr,
	input  logic                  mem_wr,
	output logic                  map_valid,
	output pager_pkg::phys_addr_t phys_addr,
	output logic                  map_rom,
	output logic                  wr_blocked,

	// page readback
	input  logic                  io_rd,
	input  logic [15:0]           io_addr,
	output logic                  io_rvalid,
	output logic [ 7:0]           io_rdata,

	win_map_if.dst                win [`PAGER_NUM_WIN]
);
	import pager_pkg::*;

	page_reg_t                 map_w [`PAGER_NUM_WIN];
	page_reg_t                 rb_w  [2*`PAGER_NUM_WIN];
	logic [`PAGER_NUM_WIN-1:0] wp_w;

	win_idx_t                  lk_idx;
	port_op_e                  rb_op;

	logic                      s1_valid;
	logic                      s1_wr;
	logic                      s1_wp;
	page_reg_t                 s1_map;
	logic [`PAGER_WIN_AW-1:0]  s1_offs;

	// flatten the window buses so they can be indexed at run time
	for (genvar w = 0; w < `PAGER_NUM_WIN; w++)
	begin : gather
		assign map_w[w]                  = win[w].map;
		assign wp_w[w]                   = win[w].wr_protect;
		assign rb_w[w]                   = win[w].reg0;
		assign rb_w[w + `PAGER_NUM_WIN]  = win[w].reg1;
	end

	////////////////////////////////////////////////////////////////////////////
	// lookup pipeline
	////////////////////////////////////////////////////////////////////////////

	assign lk_idx = mem_addr[15:14];

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			s1_valid  <= 1'b0;
			map_valid <= 1'b0;
		end
		else
		begin
			s1_valid  <= mem_valid;
			map_valid <= s1_valid;
		end
	end

	// stage 1, grab the window mapping
	always_ff @(posedge fclk)
	begin
		s1_map  <= map_w[lk_idx];
		s1_wp   <= wp_w[lk_idx];
		s1_wr   <= mem_wr;
		s1_offs <= mem_addr[`PAGER_WIN_AW-1:0];
	end

	// stage 2, build the physical address
	always_ff @(posedge fclk)
	begin
		phys_addr.page <= s1_map.page;
		phys_addr.offs <= s1_offs;
		map_rom        <= s1_map.is_rom;
		wr_blocked     <= s1_wr & s1_wp;
	end

	////////////////////////////////////////////////////////////////////////////
	// readback through xxBE
	////////////////////////////////////////////////////////////////////////////

	assign rb_op = (io_rd && io_addr[7:0] == `PAGER_LO_RB) ? PORT_RB : PORT_NONE;

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
			io_rvalid <= 1'b0;
		else
			io_rvalid <= io_rd;
	end

	always_ff @(posedge fclk)
	begin
		if (io_rd)
			io_rdata <= (rb_op == PORT_RB) ? rb_w[io_addr[10:8]] : 8'hFF;
	end

	a_lookup_latency: assert property (@(posedge fclk) disable iff (!arst_n)
		map_valid == $past(mem_valid, 2));

endmodule

// ==== rtl/mem_pager_top.sv ====
////////////////////////////////////////////////////////////////////////////
// memory paging unit, plain ports
// leave two idle cycles after an I/O write before relying on lookups
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "pager_defs.svh"

module mem_pager_top
(
	input  logic                  fclk,
	input  logic                  arst_n,

	// Z80 I/O side
	input  logic                  io_wr,
	input  logic                  io_rd,
	input  logic [15:0]           io_addr,
	input  logic [ 7:0]           io_wdata,
	output logic                  io_rvalid,
	output logic [ 7:0]           io_rdata,

	// Z80 memory side
	input  logic                  mem_valid,
	input  logic [15:0]           mem_addr,
	input  logic                  mem_wr,
	output logic                  map_valid,
	output pager_pkg::phys_addr_t phys_addr,
	output logic                  map_rom,
	output logic                  wr_blocked
);

	pager_cfg_if cfg_if ();
	win_map_if   win_if [`PAGER_NUM_WIN] ();

	port_decoder port_decoder
	(
		.fclk    (fclk      ),
		.arst_n  (arst_n    ),
		.io_wr   (io_wr     ),
		.io_addr (io_addr   ),
		.io_wdata(io_wdata  ),
		.cfg     (cfg_if.src)
	);

	// one pager per 16 KB window
	for (genvar w = 0; w < `PAGER_NUM_WIN; w++)
	begin : window_pagers
		window_pager #(.WIN(w)) window_pager
		(
			.fclk  (fclk         ),
			.arst_n(arst_n       ),
			.cfg   (cfg_if.dst   ),
			.win   (win_if[w].src)
		);
	end

	page_resolver page_resolver
	(
		.fclk      (fclk      ),
		.arst_n    (arst_n    ),
		.mem_valid (mem_valid ),
		.mem_addr  (mem_addr  ),
		.mem_wr    (mem_wr    ),
		.map_valid (map_valid ),
		.phys_addr (phys_addr ),
		.map_rom   (map_rom   ),
		.wr_blocked(wr_blocked),
		.io_rd     (io_rd     ),
		.io_addr   (io_addr   ),
		.io_rvalid (io_rvalid ),
		.io_rdata  (io_rdata  ),
		.win       (win_if    )
	);

endmodule

// ==== tb/pager_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// random test of the paging unit against a behavioral model
// the 7FFD lock test runs last since only reset clears the lock
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "pager_defs.svh"

module pager_tb;
	import pager_pkg::*;

	localparam int N_PENT  = 8;
	localparam int N_PAGER = 16;
	localparam int N_B2B   = 32;
	localparam int N_LOCK  = 6;
	// every operation takes at most 4 cycles
	localparam int OPS     = (1 + N_PENT * 7) + (1 + N_PAGER * 6) + 13 + 12 + N_B2B
		+ (2 + N_LOCK * 3);
	localparam int MAX_CYC = OPS * 4 + 100;

	typedef struct packed
	{
		phys_addr_t  addr;
		logic        rom;
		logic        blk;
		logic [31:0] issue;
	} lookup_exp_t;

	logic        fclk;
	logic        arst_n;
	logic        io_wr;
	logic        io_rd;
	logic [15:0] io_addr;
	logic [ 7:0] io_wdata;
	logic        io_rvalid;
	logic [ 7:0] io_rdata;
	logic        mem_valid;
	logic [15:0] mem_addr;
	logic        mem_wr;
	logic        map_valid;
	phys_addr_t  phys_addr;
	logic        map_rom;
	logic        wr_blocked;

	// reference model state
	logic [7:0]  m_7ffd;
	logic        m_on;
	page_reg_t   m_regs [8];
	lookup_exp_t exp_q [$];

	logic [31:0] cyc = '0;
	int          map_checks = 0;
	int          map_errors = 0;
	int          rb_checks = 0;
	int          rb_errors = 0;
	int          chk0 = 0;
	int          err0 = 0;

	mem_pager_top dut_i
	(
		.fclk      (fclk      ),
		.arst_n    (arst_n    ),
		.io_wr     (io_wr     ),
		.io_rd     (io_rd     ),
		.io_addr   (io_addr   ),
		.io_wdata  (io_wdata  ),
		.io_rvalid (io_rvalid ),
		.io_rdata  (io_rdata  ),
		.mem_valid (mem_valid ),
		.mem_addr  (mem_addr  ),
		.mem_wr    (mem_wr    ),
		.map_valid (map_valid ),
		.phys_addr (phys_addr ),
		.map_rom   (map_rom   ),
		.wr_blocked(wr_blocked)
	);

	initial
	begin
		fclk = 1'b0;
		forever #2 fclk = ~fclk;
	end

	always @(posedge fclk)
	begin
		cyc <= cyc + 1;
		if (cyc >= MAX_CYC)
		begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYC);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// model and compare tasks
	////////////////////////////////////////////////////////////////////////////

	function automatic page_reg_t model_map(input win_idx_t w);
		page_reg_t r;
		r = '0;
		if (m_on)
			r = m_regs[{m_7ffd[4], w}];
		else
		begin
			case (w)
				2'd0:
				begin
					r.is_rom = 1'b1;
					r.page   = page_t'(m_7ffd[4]);
				end
				2'd1:
					r.page = page_t'(5);
				2'd2:
					r.page = page_t'(2);
				default:
					r.page = page_t'(m_7ffd[2:0]);
			endcase
		end
		return r;
	endfunction

	task automatic check_map(input phys_addr_t got, input logic got_rom, input logic got_blk,
		input phys_addr_t exp_a, input logic exp_rom, input logic exp_blk);
		map_checks++;
		if (got !== exp_a || got_rom !== exp_rom || got_blk !== exp_blk)
		begin
			$display("[FAIL] %0d ns: lookup gave %h rom %b blk %b, expected %h rom %b blk %b",
				$time, got, got_rom, got_blk, exp_a, exp_rom, exp_blk);
			map_errors++;
		end
	endtask

	task automatic check_rb(input page_reg_t got, input page_reg_t exp_v);
		rb_checks++;
		if (got !== exp_v)
		begin
			$display("[FAIL] %0d ns: readback gave %h, expected %h", $time, got, exp_v);
			rb_errors++;
		end
	endtask

	// lookup results come out in issue order
	always @(negedge fclk)
	begin
		lookup_exp_t e;
		if (arst_n && map_valid)
		begin
			if (exp_q.size() == 0)
			begin
				$display("%0d ns: map_valid raised with no lookup outstanding", $time);
				map_errors++;
			end
			else
			begin
				e = exp_q.pop_front();
				if (cyc - e.issue != 32'd2)
				begin
					$display("[FAIL] %0d ns: lookup answered after %0d cycles, expected 2",
						$time, cyc - e.issue);
					map_errors++;
				end
				check_map(phys_addr, map_rom, wr_blocked, e.addr, e.rom, e.blk);
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// bus tasks, all driven on the falling edge
	////////////////////////////////////////////////////////////////////////////

	task automatic drive_idle(input int n);
		repeat (n)
		begin
			@(negedge fclk);
			io_wr     = 1'b0;
			io_rd     = 1'b0;
			mem_valid = 1'b0;
		end
	endtask

	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		@(negedge fclk);
		io_wr     = 1'b1;
		io_rd     = 1'b0;
		mem_valid = 1'b0;
		io_addr   = addr;
		io_wdata  = data;
		if (addr == `PAGER_PORT_7FFD)
		begin
			if (!m_7ffd[5])
				m_7ffd = data;
		end
		else if (addr[7:0] == `PAGER_LO_WIN)
			m_regs[{m_7ffd[4], addr[15:14]}] = page_reg_t'(data);
		else if (addr[7:0] == `PAGER_LO_MODE)
			m_on = data[0];
		// two quiet cycles before lookups rely on it
		drive_idle(2);
	endtask

	task automatic lookup(input logic [15:0] addr, input logic wr);
		lookup_exp_t e;
		page_reg_t   m;
		@(negedge fclk);
		io_wr       = 1'b0;
		io_rd       = 1'b0;
		mem_valid   = 1'b1;
		mem_addr    = addr;
		mem_wr      = wr;
		m           = model_map(addr[15:14]);
		e.addr.page = m.page;
		e.addr.offs = addr[`PAGER_WIN_AW-1:0];
		e.rom       = m.is_rom;
		e.blk       = wr & m.is_rom;
		e.issue     = cyc;
		exp_q.push_back(e);
	endtask

	task automatic readback(input logic [15:0] addr);
		page_reg_t exp_v;
		@(negedge fclk);
		io_wr     = 1'b0;
		io_rd     = 1'b1;
		mem_valid = 1'b0;
		io_addr   = addr;
		if (addr[7:0] == `PAGER_LO_RB)
			exp_v = m_regs[addr[10:8]];
		else
			exp_v = page_reg_t'(8'hFF);
		@(negedge fclk);
		io_rd = 1'b0;
		if (!io_rvalid)
		begin
			$display("%0d ns: io_rvalid missing one cycle after io_rd to port %h", $time, addr);
			rb_errors++;
		end
		else
			check_rb(page_reg_t'(io_rdata), exp_v);
	endtask

	task automatic report_test(input string name);
		drive_idle(1);
		while (exp_q.size() != 0)
			@(negedge fclk);
		$display("test %s done: %0d checks, %0d errors", name,
			map_checks + rb_checks - chk0, map_errors + rb_errors - err0);
		chk0 = map_checks + rb_checks;
		err0 = map_errors + rb_errors;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		arst_n    = 1'b0;
		io_wr     = 1'b0;
		io_rd     = 1'b0;
		io_addr   = '0;
		io_wdata  = '0;
		mem_valid = 1'b0;
		mem_addr  = '0;
		mem_wr    = 1'b0;
		m_7ffd    = '0;
		m_on      = 1'b0;
		foreach (m_regs[i])
			m_regs[i] = '0;
		void'($urandom(32'h7c0d_e96a));

		repeat (5) @(posedge fclk);
		@(negedge fclk);
		arst_n = 1'b1;

		// fixed pentagon mapping, lock bit kept clear
		io_write({8'($urandom()), `PAGER_LO_MODE}, 8'h00);
		repeat (N_PENT)
		begin
			io_write(`PAGER_PORT_7FFD, 8'($urandom()) & 8'hDF);
			repeat (6)
				lookup(16'($urandom()), 1'($urandom()));
		end
		report_test("pentagon");

		// pager mapping under both register sets
		io_write({8'($urandom()), `PAGER_LO_MODE}, 8'($urandom()) | 8'h01);
		repeat (N_PAGER)
		begin
			io_write(`PAGER_PORT_7FFD, 8'($urandom()) & 8'hDF);
			io_write({8'($urandom()), `PAGER_LO_WIN}, 8'($urandom()));
			for (int i = 0; i < 4; i++)
				lookup({2'(i), 14'($urandom())}, 1'($urandom()));
		end
		report_test("pager");

		// ROM in windows 0 and 2, RAM in 1 and 3
		io_write(`PAGER_PORT_7FFD, 8'h00);
		for (int i = 0; i < 4; i++)
			io_write({2'(i), 6'($urandom()), `PAGER_LO_WIN}, {~i[0], 7'($urandom())});
		for (int i = 0; i < 4; i++)
		begin
			lookup({2'(i), 14'($urandom())}, 1'b0);
			lookup({2'(i), 14'($urandom())}, 1'b1);
		end
		report_test("protect");

		for (int i = 0; i < 8; i++)
			readback({5'($urandom()), 3'(i), `PAGER_LO_RB});
		// odd low byte never hits xxBE
		repeat (4)
			readback({8'($urandom()), 8'($urandom()) | 8'h01});
		report_test("readback");

		repeat (N_B2B)
			lookup(16'($urandom()), 1'($urandom()));
		report_test("back2back");

		// locked 7FFD ignores later writes
		io_write({8'($urandom()), `PAGER_LO_MODE}, 8'h00);
		io_write(`PAGER_PORT_7FFD, 8'($urandom()) | 8'h20);
		repeat (N_LOCK)
		begin
			io_write(`PAGER_PORT_7FFD, 8'($urandom()));
			lookup({2'b00, 14'($urandom())}, 1'b0);
			lookup({2'b11, 14'($urandom())}, 1'b0);
		end
		report_test("lock");

		$display("total: %0d checks, %0d errors", map_checks + rb_checks,
			map_errors + rb_errors);
		if (map_errors + rb_errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+rtl
rtl/pager_pkg.sv
rtl/pager_ifs.sv
rtl/port_decoder.sv
rtl/window_pager.sv
rtl/page_resolver.sv
rtl/mem_pager_top.sv
tb/pager_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the paging unit testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
	--timescale 1ns/1ps \
	--top-module pager_tb \
	-Mdir "$BUILD_DIR" \
	-f files.f
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

"./$BUILD_DIR/Vpager_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG"; then
	exit 1
fi
exit 0
